// File: source/nabp_params.svh
`ifndef NABP_PARAMS_SVH
`define NABP_PARAMS_SVH

// filtered sample width
`define NABP_FILTERED_DATA_LENGTH 12

// projection line address width, 256 samples per line
`define NABP_S_LENGTH 8

// number of taps, one per processing element
`define NABP_NO_OF_PARTITIONS 4
// samples between neighbouring taps
`define NABP_PARTITION_SIZE 8

// mapper fixed-point accumulator
`define NABP_ACCU_WIDTH 16
`define NABP_ACCU_FRAC 8

// iterations between swap requests
`define NABP_ITRS_PER_SWAP 3

`endif

// File: source/nabp_data_pkg.sv
`include "nabp_params.svh"

package nabp_data_pkg;

    // one filtered projection sample
    typedef logic signed [`NABP_FILTERED_DATA_LENGTH-1:0] sample_t;

    // address into the filtered RAM
    typedef logic [`NABP_S_LENGTH-1:0] s_val_t;

    // unsigned fixed point, NABP_ACCU_FRAC fractional bits
    typedef logic [`NABP_ACCU_WIDTH-1:0] accu_t;

endpackage

// File: source/nabp_ctrl_pkg.sv
`include "nabp_params.svh"

package nabp_ctrl_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        SC_SWAP_WAIT     = 2'd0,
        SC_FILL          = 2'd1,
        SC_SHIFT         = 2'd2,
        SC_NEXT_ITR_WAIT = 2'd3
    } sc_state_t;

    // iterations since the last swap
    typedef logic [1:0] itr_cnt_t;

    // fill and shift phase timer, sized for the longer fill phase
    typedef logic [$clog2((`NABP_NO_OF_PARTITIONS - 1) * `NABP_PARTITION_SIZE) - 1:0]
        phase_cnt_t;

endpackage

// File: source/nabp_state_control.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_state_control (
    input  logic                 clk,
    input  logic                 rst,
    input  nabp_data_pkg::accu_t sw_mp_accu_init,
    input  nabp_data_pkg::accu_t sw_mp_accu_base,
    input  logic                 sw_swap_ack,
    input  logic                 sw_next_itr_ack,
    input  logic                 fill_done,
    input  logic                 shift_done,
    output logic                 sw_swap,
    output logic                 sw_next_itr,
    output logic                 sh_fill_kick,
    output logic                 sh_shift_kick,
    output nabp_data_pkg::accu_t mp_accu_init,
    output nabp_data_pkg::accu_t mp_accu_base
);
    import nabp_ctrl_pkg::*;

    sc_state_t state;
    itr_cnt_t  itr_cnt;
    logic      base_load;

    // an acknowledge only counts in the state that asked for it
    assign base_load = (state == SC_SWAP_WAIT && sw_swap_ack) ||
                       (state == SC_NEXT_ITR_WAIT && sw_next_itr_ack);

    // request levels decoded straight from the state
    assign sw_swap     = (state == SC_SWAP_WAIT);
    assign sw_next_itr = (state == SC_NEXT_ITR_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= SC_SWAP_WAIT;
            itr_cnt       <= '0;
            sh_fill_kick  <= 1'b0;
            sh_shift_kick <= 1'b0;
        end else begin
            sh_fill_kick  <= 1'b0;
            sh_shift_kick <= 1'b0;
            case (state)
                SC_SWAP_WAIT, SC_NEXT_ITR_WAIT: begin
                    if (base_load) begin
                        state        <= SC_FILL;
                        sh_fill_kick <= 1'b1;
                    end
                end
                SC_FILL: begin
                    if (fill_done) begin
                        state         <= SC_SHIFT;
                        sh_shift_kick <= 1'b1;
                    end
                end
                SC_SHIFT: begin
                    // last iteration before a swap goes back to swap wait
                    if (shift_done) begin
                        if (itr_cnt == itr_cnt_t'(`NABP_ITRS_PER_SWAP - 1)) begin
                            state   <= SC_SWAP_WAIT;
                            itr_cnt <= '0;
                        end else begin
                            state   <= SC_NEXT_ITR_WAIT;
                            itr_cnt <= itr_cnt + itr_cnt_t'(1);
                        end
                    end
                end
                default: state <= SC_SWAP_WAIT;
            endcase
        end
    end

    // bases are valid only with the acknowledge pulse
    always_ff @(posedge clk) begin
        if (base_load) begin
            mp_accu_init <= sw_mp_accu_init;
            mp_accu_base <= sw_mp_accu_base;
        end
    end

    a_swap_ack_requested: assert property (@(posedge clk) disable iff (rst)
        sw_swap_ack |-> sw_swap);

    a_next_itr_ack_requested: assert property (@(posedge clk) disable iff (rst)
        sw_next_itr_ack |-> sw_next_itr);

    a_fill_done_state: assert property (@(posedge clk) disable iff (rst)
        fill_done |-> state == SC_FILL);

    a_shift_done_state: assert property (@(posedge clk) disable iff (rst)
        shift_done |-> state == SC_SHIFT);

endmodule

// File: source/nabp_shifter.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_shifter (
    input  logic clk,
    input  logic rst,
    input  logic fill_kick,
    input  logic shift_kick,
    output logic fill_done,
    output logic shift_done,
    output logic mp_kick,
    output logic mp_shift_en,
    output logic mp_done,
    output logic tap_en,
    output logic sw_pe_en
);
    import nabp_ctrl_pkg::*;

    localparam int FILL_LEN  = (`NABP_NO_OF_PARTITIONS - 1) * `NABP_PARTITION_SIZE;
    localparam int SHIFT_LEN = `NABP_PARTITION_SIZE;

    logic       filling;
    logic       shifting;
    phase_cnt_t cnt;
    logic       sweep_end;
    // address register and RAM read latency
    logic       en_d1;
    logic       en_d2;
    logic       pe_d1;
    logic       pe_d2;

    // mapper loads its start value while the kick is up
    assign mp_kick     = fill_kick;
    assign mp_shift_en = filling | shifting;
    assign mp_done     = sweep_end;
    assign shift_done  = sweep_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            filling   <= 1'b0;
            shifting  <= 1'b0;
            cnt       <= '0;
            fill_done <= 1'b0;
            sweep_end <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            sweep_end <= 1'b0;
            if (fill_kick) begin
                filling <= 1'b1;
                cnt     <= '0;
            end else if (shift_kick) begin
                shifting <= 1'b1;
                cnt      <= '0;
            end else if (filling) begin
                cnt <= cnt + phase_cnt_t'(1);
                if (cnt == phase_cnt_t'(FILL_LEN - 1)) begin
                    filling   <= 1'b0;
                    fill_done <= 1'b1;
                end
            end else if (shifting) begin
                cnt <= cnt + phase_cnt_t'(1);
                if (cnt == phase_cnt_t'(SHIFT_LEN - 1)) begin
                    shifting  <= 1'b0;
                    sweep_end <= 1'b1;
                end
            end
        end
    end

    // the phase tag travels with its enable, so the PE strobe only marks shift samples
    always_ff @(posedge clk) begin
        if (rst) begin
            en_d1 <= 1'b0;
            en_d2 <= 1'b0;
            pe_d1 <= 1'b0;
            pe_d2 <= 1'b0;
        end else begin
            en_d1 <= mp_shift_en;
            en_d2 <= en_d1;
            pe_d1 <= shifting;
            pe_d2 <= pe_d1;
        end
    end

    assign tap_en   = en_d2;
    assign sw_pe_en = pe_d2;

    a_kick_when_idle: assert property (@(posedge clk) disable iff (rst)
        (fill_kick || shift_kick) |-> !(filling || shifting));

endmodule

// File: source/nabp_mapper.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_mapper (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  kick,
    input  logic                  shift_en,
    input  logic                  done,
    input  nabp_data_pkg::accu_t  accu_init,
    input  nabp_data_pkg::accu_t  accu_base,
    output nabp_data_pkg::s_val_t fr_s_val
);
    import nabp_data_pkg::*;

    accu_t accu;
    // set by kick, cleared at the end of the sweep
    logic  active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            accu     <= '0;
            fr_s_val <= '0;
        end else if (kick) begin
            active <= 1'b1;
            accu   <= accu_init;
        end else begin
            if (shift_en && active) begin
                // integer part, wraps around the 256-sample line
                fr_s_val <= accu[`NABP_ACCU_FRAC +: `NABP_S_LENGTH];
                accu     <= accu + accu_base;
            end
            // address stays put until the next kick
            if (done) begin
                active <= 1'b0;
            end
        end
    end

endmodule

// File: source/nabp_tap_segment.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_tap_segment #(
    parameter type payload_t = nabp_data_pkg::sample_t,
    parameter int  depth     = `NABP_PARTITION_SIZE
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     clr,
    input  logic     en,
    input  payload_t din,
    output payload_t dout
);

    // entry 0 is the newest sample
    payload_t sr [depth];

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            sr <= '{default: '0};
        end else if (en) begin
            sr[0] <= din;
            for (int i = 1; i < depth; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    // din seen depth enables ago
    assign dout = sr[depth-1];

endmodule

// File: source/nabp_processing_swappable.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_processing_swappable (
    input  logic                  clk,
    input  logic                  rst,
    input  nabp_data_pkg::accu_t  sw_mp_accu_init,
    input  nabp_data_pkg::accu_t  sw_mp_accu_base,
    input  logic                  sw_swap_ack,
    input  logic                  sw_next_itr_ack,
    input  nabp_data_pkg::sample_t fr_val,
    output logic                  sw_swap,
    output logic                  sw_next_itr,
    output logic                  sw_pe_en,
    output nabp_data_pkg::s_val_t fr_s_val,
    output logic [`NABP_NO_OF_PARTITIONS*`NABP_FILTERED_DATA_LENGTH-1:0] pe_taps
);
    import nabp_data_pkg::*;

    logic    fill_kick;
    logic    shift_kick;
    logic    fill_done;
    logic    shift_done;
    logic    mp_kick;
    logic    mp_shift_en;
    logic    mp_done;
    logic    tap_en;
    accu_t   mp_accu_init;
    accu_t   mp_accu_base;
    sample_t tap0;
    sample_t tap_chain [`NABP_NO_OF_PARTITIONS];

    nabp_state_control i_state_control (
        .clk             (clk),
        .rst             (rst),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .fill_done       (fill_done),
        .shift_done      (shift_done),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sh_fill_kick    (fill_kick),
        .sh_shift_kick   (shift_kick),
        .mp_accu_init    (mp_accu_init),
        .mp_accu_base    (mp_accu_base)
    );

    nabp_shifter i_shifter (
        .clk         (clk),
        .rst         (rst),
        .fill_kick   (fill_kick),
        .shift_kick  (shift_kick),
        .fill_done   (fill_done),
        .shift_done  (shift_done),
        .mp_kick     (mp_kick),
        .mp_shift_en (mp_shift_en),
        .mp_done     (mp_done),
        .tap_en      (tap_en),
        .sw_pe_en    (sw_pe_en)
    );

    nabp_mapper i_mapper (
        .clk       (clk),
        .rst       (rst),
        .kick      (mp_kick),
        .shift_en  (mp_shift_en),
        .done      (mp_done),
        .accu_init (mp_accu_init),
        .accu_base (mp_accu_base),
        .fr_s_val  (fr_s_val)
    );

    // first tap takes the RAM output directly
    always_ff @(posedge clk) begin
        if (rst || fill_kick) begin
            tap0 <= '0;
        end else if (tap_en) begin
            tap0 <= fr_val;
        end
    end

    assign tap_chain[0] = tap0;

    // a full set of taps is visible the cycle after sw_pe_en
    for (genvar g = 0; g < `NABP_NO_OF_PARTITIONS; g++) begin : g_tap
        if (g > 0) begin : g_seg
            nabp_tap_segment #(
                .payload_t (sample_t),
                .depth     (`NABP_PARTITION_SIZE)
            ) i_tap_segment (
                .clk  (clk),
                .rst  (rst),
                .clr  (fill_kick),
                .en   (tap_en),
                .din  (tap_chain[g-1]),
                .dout (tap_chain[g])
            );
        end
        assign pe_taps[g*`NABP_FILTERED_DATA_LENGTH +: `NABP_FILTERED_DATA_LENGTH] = tap_chain[g];
    end

endmodule

// File: dv/nabp_processing_tb.sv
`timescale 1ns/1ps
`include "nabp_params.svh"

module nabp_processing_tb;
    import nabp_data_pkg::*;
    import nabp_ctrl_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int ITR_COUNT      = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + ITR_COUNT * 60;
    localparam int SWEEP_LEN      = `NABP_NO_OF_PARTITIONS * `NABP_PARTITION_SIZE;
    localparam int TAP_W          = `NABP_FILTERED_DATA_LENGTH;

    // one row per iteration
    typedef struct packed {
        accu_t init;
        accu_t base;
    } itr_entry_t;

    logic        clk;
    logic        rst;
    accu_t       sw_mp_accu_init;
    accu_t       sw_mp_accu_base;
    logic        sw_swap_ack;
    logic        sw_next_itr_ack;
    sample_t     fr_val;
    logic        sw_swap;
    logic        sw_next_itr;
    logic        sw_pe_en;
    s_val_t      fr_s_val;
    logic [`NABP_NO_OF_PARTITIONS*TAP_W-1:0] pe_taps;

    itr_entry_t  itr_tbl [ITR_COUNT];
    s_val_t      addr_q;
    int          cycle_cnt;
    int          pe_en_cycles;
    itr_cnt_t    itrs_since_swap;
    logic        expect_swap;

    nabp_processing_swappable i_nabp_processing_swappable (
        .clk             (clk),
        .rst             (rst),
        .sw_mp_accu_init (sw_mp_accu_init),
        .sw_mp_accu_base (sw_mp_accu_base),
        .sw_swap_ack     (sw_swap_ack),
        .sw_next_itr_ack (sw_next_itr_ack),
        .fr_val          (fr_val),
        .sw_swap         (sw_swap),
        .sw_next_itr     (sw_next_itr),
        .sw_pe_en        (sw_pe_en),
        .fr_s_val        (fr_s_val),
        .pe_taps         (pe_taps)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // filtered line contents
    function automatic sample_t ram_word(input int unsigned idx);
        return sample_t'((idx * 37 + 5) % 4096);
    endfunction

    // integer part of init + k*base on the 256-sample line
    function automatic s_val_t expected_addr(input accu_t init, input accu_t base, input int k);
        int unsigned sum;
        sum = init + k * base;
        return s_val_t'(sum >> `NABP_ACCU_FRAC);
    endfunction

    // sweep index shown on fr_s_val n cycles after the ack edge, -1 when not defined
    function automatic int addr_index_at(input int n);
        if (n < 2)
            return -1;
        if (n <= 25)
            return n - 2;
        if (n <= 27)
            return 23;
        if (n <= 35)
            return n - 4;
        return SWEEP_LEN - 1;
    endfunction

    // RAM model, one cycle of read latency
    initial begin
        fr_val = '0;
        addr_q = '0;
        forever begin
            @(posedge clk);
            #2;
            fr_val = ram_word(addr_q);
            addr_q = fr_s_val;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s actual 'h%0h expected 'h%0h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // every cycle after reset passes through here
    task automatic next_cycle();
        @(posedge clk);
        #2;
        if (sw_pe_en)
            pe_en_cycles++;
    endtask

    task automatic wait_for_request();
        while (!(sw_swap || sw_next_itr)) begin
            next_cycle();
        end
        check_value("sw_swap & sw_next_itr", sw_swap & sw_next_itr, 0);
    endtask

    task automatic run_iteration(input itr_entry_t entry, input logic swap);
        s_val_t addrs [SWEEP_LEN];
        int     idx;
        int     j;
        for (int k = 0; k < SWEEP_LEN; k++) begin
            addrs[k] = expected_addr(entry.init, entry.base, k);
        end
        sw_mp_accu_init = entry.init;
        sw_mp_accu_base = entry.base;
        sw_swap_ack     = swap;
        sw_next_itr_ack = !swap;
        // n counts cycles after the edge that takes the ack
        for (int n = 0; n < 38; n++) begin
            next_cycle();
            if (n == 0) begin
                sw_swap_ack     = 1'b0;
                sw_next_itr_ack = 1'b0;
                sw_mp_accu_init = '0;
                sw_mp_accu_base = '0;
            end
            idx = addr_index_at(n);
            if (idx >= 0)
                check_value("fr_s_val", fr_s_val, addrs[idx]);
            check_value("sw_pe_en", sw_pe_en, (n >= 29 && n <= 36));
            // taps settle one cycle after each pe strobe
            if (n >= 30) begin
                j = n - 30;
                for (int t = 0; t < `NABP_NO_OF_PARTITIONS; t++) begin
                    check_value($sformatf("pe_taps[%0d]", t),
                                sample_t'(pe_taps[t*TAP_W +: TAP_W]),
                                ram_word(addrs[24 + j - 8 * t]));
                end
            end
            if (n < 36)
                check_value("sw_swap | sw_next_itr", sw_swap | sw_next_itr, 0);
        end
    endtask

    initial begin
        int unsigned delay;
        void'($urandom(32'h4296));
        cycle_cnt       = 0;
        pe_en_cycles    = 0;
        // a swap is due straight out of reset
        itrs_since_swap = itr_cnt_t'(`NABP_ITRS_PER_SWAP);
        expect_swap     = 1'b1;
        rst             = 1'b1;
        sw_mp_accu_init = '0;
        sw_mp_accu_base = '0;
        sw_swap_ack     = 1'b0;
        sw_next_itr_ack = 1'b0;

        itr_tbl[0] = '{init: 16'h0000, base: 16'h0100};
        itr_tbl[1] = '{init: 16'h1280, base: 16'h0180};
        itr_tbl[2] = '{init: 16'hF000, base: 16'h0240};
        itr_tbl[3] = '{init: 16'h4040, base: 16'h00C0};
        itr_tbl[4] = '{init: 16'h8000, base: 16'hFF00};
        itr_tbl[5] = '{init: 16'h2A55, base: 16'h0333};

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        check_value("sw_swap", sw_swap, 1);
        check_value("sw_next_itr", sw_next_itr, 0);
        check_value("sw_pe_en", sw_pe_en, 0);
        check_value("pe_taps", pe_taps, 0);

        for (int i = 0; i < ITR_COUNT; i++) begin
            wait_for_request();
            check_value("sw_pe_en cycles", pe_en_cycles, i * `NABP_PARTITION_SIZE);
            expect_swap = (itrs_since_swap == itr_cnt_t'(`NABP_ITRS_PER_SWAP));
            check_value("sw_swap", sw_swap, expect_swap);
            check_value("sw_next_itr", sw_next_itr, !expect_swap);
            if (expect_swap)
                itrs_since_swap = '0;
            // late acknowledge, request must hold
            delay = $urandom % 4;
            repeat (delay) begin
                next_cycle();
                check_value("sw_swap", sw_swap, expect_swap);
                check_value("sw_next_itr", sw_next_itr, !expect_swap);
            end
            run_iteration(itr_tbl[i], expect_swap);
            itrs_since_swap = itrs_since_swap + itr_cnt_t'(1);
        end

        // third iteration since the last swap asks for a swap again
        wait_for_request();
        check_value("sw_pe_en cycles", pe_en_cycles, ITR_COUNT * `NABP_PARTITION_SIZE);
        expect_swap = (itrs_since_swap == itr_cnt_t'(`NABP_ITRS_PER_SWAP));
        check_value("sw_swap", sw_swap, expect_swap);
        check_value("sw_next_itr", sw_next_itr, !expect_swap);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/nabp_data_pkg.sv
source/nabp_ctrl_pkg.sv
source/nabp_state_control.sv
source/nabp_shifter.sv
source/nabp_mapper.sv
source/nabp_tap_segment.sv
source/nabp_processing_swappable.sv
dv/nabp_processing_tb.sv
